//--- dma_pkg.sv
// dma_pkg: widths, buffer depth, register map, control states and AXI response codes
package dma_pkg;

    parameter int ADDR_W    = 32;
    parameter int DATA_W    = 32;
    parameter int BUF_DEPTH = 16;   // also the longest burst, len+1 beats
    parameter int LEN_W     = 8;    // as AXI4 AxLEN

    // register word index, taken from wb_adr[3:2]
    typedef enum logic [1:0] {
        REG_SRC  = 2'd0,
        REG_DST  = 2'd1,
        REG_LEN  = 2'd2,
        REG_CTRL = 2'd3
    } reg_sel_e;

    typedef enum logic [2:0] {
        IDLE,
        RD_REQ,
        RD_DATA,
        WR_REQ,
        WR_DATA,
        WR_RESP,
        FINISH
    } dma_state_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

//--- axi4_burst_master.sv
// axi4_burst_master: AXI4 INCR burst master with separate write and read FSMs
`timescale 1ns/1ps

module axi4_burst_master #(
    parameter int ADDR_W = dma_pkg::ADDR_W,
    parameter int DATA_W = dma_pkg::DATA_W
) (
    input  logic                      clk,
    input  logic                      rst,
    // user side, read path
    input  logic                      rd_req,
    input  logic [ADDR_W-1:0]         rd_addr,
    input  logic [dma_pkg::LEN_W-1:0] rd_len,
    output logic                      rd_done,
    output dma_pkg::axi_resp_e        rd_resp,
    output logic                      beat_valid,
    output logic [DATA_W-1:0]         beat_data,
    // user side, write path
    input  logic                      wr_req,
    input  logic [ADDR_W-1:0]         wr_addr,
    input  logic [dma_pkg::LEN_W-1:0] wr_len,
    input  logic [DATA_W-1:0]         wr_data,
    input  logic                      fill_ready,
    output logic                      pop,
    output logic                      wr_done,
    output dma_pkg::axi_resp_e        wr_resp,
    // AXI4 write address
    output logic [ADDR_W-1:0]         awaddr,
    output logic [dma_pkg::LEN_W-1:0] awlen,
    output logic                      awvalid,
    input  logic                      awready,
    // AXI4 write data
    output logic [DATA_W-1:0]         wdata,
    output logic [DATA_W/8-1:0]       wstrb,
    output logic                      wlast,
    output logic                      wvalid,
    input  logic                      wready,
    // AXI4 write response
    input  logic [1:0]                bresp,
    input  logic                      bvalid,
    output logic                      bready,
    // AXI4 read address
    output logic [ADDR_W-1:0]         araddr,
    output logic [dma_pkg::LEN_W-1:0] arlen,
    output logic                      arvalid,
    input  logic                      arready,
    // AXI4 read data
    input  logic [DATA_W-1:0]         rdata,
    input  logic [1:0]                rresp,
    input  logic                      rlast,
    input  logic                      rvalid,
    output logic                      rready
);
    import dma_pkg::*;

    typedef enum logic [2:0] {W_IDLE, W_AW_W, W_AW, W_W, W_NEXT, W_BRESP} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_AR, R_DATA} rd_state_e;

    wr_state_e        w_state;
    rd_state_e        r_state;
    logic [LEN_W-1:0] w_cnt;    // index of the beat on the W channel

    assign wstrb      = '1;     // full-width beats only
    assign beat_valid = rvalid & rready;
    assign beat_data  = rdata;
    assign wr_done    = (w_state == W_BRESP) && bvalid;
    // a beat leaves the buffer whenever it is loaded into wdata
    assign pop = ((w_state == W_IDLE) && wr_req) || ((w_state == W_NEXT) && fill_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            w_state <= W_IDLE;
            w_cnt   <= '0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            wlast   <= 1'b0;
            bready  <= 1'b0;
            wr_resp <= OKAY;
        end else begin
            case (w_state)
                W_IDLE: begin
                    if (wr_req) begin
                        awaddr  <= wr_addr;
                        awlen   <= wr_len;
                        wdata   <= wr_data;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        w_cnt   <= '0;
                        wlast   <= (wr_len == '0);
                        bready  <= (wr_len == '0);
                        w_state <= W_AW_W;
                    end
                end
                W_AW_W: begin
                    if (awready && wready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b0;
                        w_state <= wlast ? W_BRESP : W_NEXT;
                    end else if (awready) begin
                        awvalid <= 1'b0;
                        w_state <= W_W;
                    end else if (wready) begin
                        wvalid  <= 1'b0;
                        w_state <= W_AW;
                    end
                end
                W_AW: begin     // beat taken, address still pending
                    if (awready) begin
                        awvalid <= 1'b0;
                        w_state <= wlast ? W_BRESP : W_NEXT;
                    end
                end
                W_W: begin
                    if (wready) begin
                        wvalid  <= 1'b0;
                        w_state <= wlast ? W_BRESP : W_NEXT;
                    end
                end
                W_NEXT: begin
                    if (fill_ready) begin
                        wdata   <= wr_data;
                        wvalid  <= 1'b1;
                        w_cnt   <= w_cnt + 1'b1;
                        wlast   <= (w_cnt + 1'b1 == awlen);
                        bready  <= (w_cnt + 1'b1 == awlen);
                        w_state <= W_W;
                    end
                end
                W_BRESP: begin
                    if (bvalid) begin
                        wr_resp <= axi_resp_e'(bresp);
                        bready  <= 1'b0;
                        wlast   <= 1'b0;
                        w_state <= W_IDLE;
                    end
                end
                default: w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_state <= R_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            rd_done <= 1'b0;
            rd_resp <= OKAY;
        end else begin
            rd_done <= 1'b0;
            case (r_state)
                R_IDLE: begin
                    if (rd_req) begin
                        araddr  <= rd_addr;
                        arlen   <= rd_len;
                        arvalid <= 1'b1;
                        rready  <= 1'b1;    // buffer always has room
                        rd_resp <= OKAY;
                        r_state <= R_AR;
                    end
                end
                R_AR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        r_state <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (rvalid) begin
                        // keep the worst error seen in the burst
                        if (rresp[1] && (rresp > rd_resp))
                            rd_resp <= axi_resp_e'(rresp);
                        if (rlast) begin
                            rready  <= 1'b0;
                            rd_done <= 1'b1;    // rd_resp already final here
                            r_state <= R_IDLE;
                        end
                    end
                end
                default: r_state <= R_IDLE;
            endcase
        end
    end

endmodule

//--- burst_buffer.sv
// burst_buffer: circular FIFO holding read beats for the write burst
`timescale 1ns/1ps

module burst_buffer #(
    parameter int DATA_W    = dma_pkg::DATA_W,
    parameter int BUF_DEPTH = dma_pkg::BUF_DEPTH
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    output logic [DATA_W-1:0] head_data,
    output logic              not_empty
);
    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [DATA_W-1:0] mem [BUF_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    assign head_data = mem[rd_ptr];
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

//--- wb_dma_regs.sv
// wb_dma_regs: Wishbone classic slave with source, destination, length, control and status
`timescale 1ns/1ps

module wb_dma_regs #(
    parameter int ADDR_W = dma_pkg::ADDR_W,
    parameter int DATA_W = dma_pkg::DATA_W
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [ADDR_W-1:0]         wb_adr,
    input  logic [DATA_W-1:0]         wb_wdata,
    output logic [DATA_W-1:0]         wb_rdata,
    output logic                      wb_ack,
    input  logic                      busy,
    input  logic                      done_set,
    input  logic                      err_set,
    input  dma_pkg::axi_resp_e        err_code,
    output logic [ADDR_W-1:0]         src_addr,
    output logic [ADDR_W-1:0]         dst_addr,
    output logic [dma_pkg::LEN_W-1:0] burst_len,
    output logic                      start
);
    import dma_pkg::*;

    reg_sel_e  sel;
    logic      wr_en;
    logic      done_q;
    axi_resp_e err_q;

    assign sel   = reg_sel_e'(wb_adr[3:2]);     // word index
    assign wr_en = wb_ack && wb_cyc && wb_stb && wb_we;
    assign start = wr_en && (sel == REG_CTRL) && wb_wdata[0] && !busy;

    // one-cycle ack, drops even if stb stays up
    always_ff @(posedge clk) begin
        if (rst)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (sel)
                REG_SRC: src_addr  <= ADDR_W'(wb_wdata);
                REG_DST: dst_addr  <= ADDR_W'(wb_wdata);
                REG_LEN: burst_len <= wb_wdata[LEN_W-1:0];
                default: ;      // ctrl handled by start
            endcase
        end
    end

    // sticky status, cleared by the next start
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
            err_q  <= OKAY;
        end else if (start) begin
            done_q <= 1'b0;
            err_q  <= OKAY;
        end else begin
            if (done_set)
                done_q <= 1'b1;
            if (err_set)
                err_q <= err_code;
        end
    end

    always_comb begin
        case (sel)
            REG_SRC: wb_rdata = DATA_W'(src_addr);
            REG_DST: wb_rdata = DATA_W'(dst_addr);
            REG_LEN: wb_rdata = DATA_W'(burst_len);
            default: wb_rdata = {{(DATA_W - 4){1'b0}}, err_q, done_q, busy};
        endcase
    end

endmodule

//--- dma_ctrl.sv
// dma_ctrl: FSM that runs the read burst, the write burst and the status update
`timescale 1ns/1ps

module dma_ctrl #(
    parameter int ADDR_W = dma_pkg::ADDR_W
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [ADDR_W-1:0]         src_addr,
    input  logic [ADDR_W-1:0]         dst_addr,
    input  logic [dma_pkg::LEN_W-1:0] burst_len,
    input  logic                      rd_done,
    input  dma_pkg::axi_resp_e        rd_resp,
    input  logic                      wr_done,
    input  dma_pkg::axi_resp_e        wr_resp,
    output logic                      busy,
    output logic                      done_set,
    output logic                      err_set,
    output dma_pkg::axi_resp_e        err_code,
    output logic                      rd_req,
    output logic [ADDR_W-1:0]         rd_addr,
    output logic [dma_pkg::LEN_W-1:0] rd_len,
    output logic                      wr_req,
    output logic [ADDR_W-1:0]         wr_addr,
    output logic [dma_pkg::LEN_W-1:0] wr_len
);
    import dma_pkg::*;

    dma_state_e       state;
    axi_resp_e        err_q;
    logic [ADDR_W-1:0] src_q;
    logic [ADDR_W-1:0] dst_q;
    logic [LEN_W-1:0]  len_q;

    assign busy     = (state != IDLE);
    assign rd_req   = (state == RD_REQ);
    assign wr_req   = (state == WR_REQ);
    assign done_set = (state == FINISH);
    assign err_set  = (state == FINISH) && (err_q != OKAY);
    assign err_code = err_q;
    assign rd_addr  = src_q;
    assign wr_addr  = dst_q;
    assign rd_len   = len_q;
    assign wr_len   = len_q;

    // copy parameters frozen for the whole transfer
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            src_q <= src_addr;
            dst_q <= dst_addr;
            len_q <= burst_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            err_q <= OKAY;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        err_q <= OKAY;
                        state <= RD_REQ;
                    end
                end
                RD_REQ:  state <= RD_DATA;
                RD_DATA: begin
                    if (rd_done) begin
                        if (rd_resp != OKAY) begin     // nothing valid to write
                            err_q <= rd_resp;
                            state <= FINISH;
                        end else begin
                            state <= WR_REQ;
                        end
                    end
                end
                WR_REQ:  state <= WR_DATA;
                WR_DATA: begin
                    if (wr_done)
                        state <= WR_RESP;
                end
                WR_RESP: begin
                    err_q <= wr_resp;   // held by the master after bvalid
                    state <= FINISH;
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- dma_top.sv
// dma_top: register file, controller, burst buffer and AXI4 master
`timescale 1ns/1ps

module dma_top #(
    parameter int ADDR_W    = dma_pkg::ADDR_W,
    parameter int DATA_W    = dma_pkg::DATA_W,
    parameter int BUF_DEPTH = dma_pkg::BUF_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    // Wishbone slave
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [ADDR_W-1:0]         wb_adr,
    input  logic [DATA_W-1:0]         wb_wdata,
    output logic [DATA_W-1:0]         wb_rdata,
    output logic                      wb_ack,
    // AXI4 master
    output logic [ADDR_W-1:0]         awaddr,
    output logic [dma_pkg::LEN_W-1:0] awlen,
    output logic                      awvalid,
    input  logic                      awready,
    output logic [DATA_W-1:0]         wdata,
    output logic [DATA_W/8-1:0]       wstrb,
    output logic                      wlast,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic [1:0]                bresp,
    input  logic                      bvalid,
    output logic                      bready,
    output logic [ADDR_W-1:0]         araddr,
    output logic [dma_pkg::LEN_W-1:0] arlen,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [DATA_W-1:0]         rdata,
    input  logic [1:0]                rresp,
    input  logic                      rlast,
    input  logic                      rvalid,
    output logic                      rready
);
    import dma_pkg::*;

    logic [ADDR_W-1:0] src_addr, dst_addr, rd_addr, wr_addr;
    logic [LEN_W-1:0]  burst_len, rd_len, wr_len;
    logic              start, busy, done_set, err_set;
    axi_resp_e         err_code, rd_resp, wr_resp;
    logic              rd_req, rd_done, wr_req, wr_done;
    logic              beat_valid, fill_ready, pop;
    logic [DATA_W-1:0] beat_data, head_data;

    wb_dma_regs #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) regs0 (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
        .busy, .done_set, .err_set, .err_code,
        .src_addr, .dst_addr, .burst_len, .start
    );

    dma_ctrl #(.ADDR_W(ADDR_W)) ctrl0 (
        .clk, .rst, .start, .src_addr, .dst_addr, .burst_len,
        .rd_done, .rd_resp, .wr_done, .wr_resp,
        .busy, .done_set, .err_set, .err_code,
        .rd_req, .rd_addr, .rd_len, .wr_req, .wr_addr, .wr_len
    );

    burst_buffer #(.DATA_W(DATA_W), .BUF_DEPTH(BUF_DEPTH)) buf0 (
        .clk, .rst, .push(beat_valid), .push_data(beat_data), .pop,
        .head_data, .not_empty(fill_ready)
    );

    axi4_burst_master #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) axi0 (
        .clk, .rst,
        .rd_req, .rd_addr, .rd_len, .rd_done, .rd_resp, .beat_valid, .beat_data,
        .wr_req, .wr_addr, .wr_len, .wr_data(head_data), .fill_ready, .pop,
        .wr_done, .wr_resp,
        .awaddr, .awlen, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arlen, .arvalid, .arready,
        .rdata, .rresp, .rlast, .rvalid, .rready
    );

endmodule

//--- tb_axi_mem.sv
// tb_axi_mem: AXI4 slave memory model with random stalls, an error region and a backdoor load port
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter int ADDR_W = dma_pkg::ADDR_W,
    parameter int DATA_W = dma_pkg::DATA_W
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall_en,
    // backdoor load port that bypasses the bus
    input  logic                      bd_we,
    input  logic [9:0]                bd_idx,
    input  logic [DATA_W-1:0]         bd_wdata,
    input  logic [ADDR_W-1:0]         awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [DATA_W-1:0]         wdata,
    input  logic                      wlast,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [ADDR_W-1:0]         araddr,
    input  logic [dma_pkg::LEN_W-1:0] arlen,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [DATA_W-1:0]         rdata,
    output logic [1:0]                rresp,
    output logic                      rlast,
    output logic                      rvalid,
    input  logic                      rready
);
    import dma_pkg::*;

    localparam logic [ADDR_W-1:0] ERR_BASE = ADDR_W'(32'h0000_3000);

    logic [DATA_W-1:0] mem [1024];
    logic [31:0]       lcg;
    logic              aw_have, w_err, b_pend;
    logic [9:0]        w_idx;
    logic              ar_have, r_err;
    logic [9:0]        r_idx;
    logic [LEN_W-1:0]  r_left;      // beats still to send after the current one

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    always @(posedge clk) begin
        if (bd_we)
            mem[bd_idx] <= bd_wdata;
        if (rst) begin
            lcg     <= 32'd35;
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= OKAY;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rresp   <= OKAY;
            rdata   <= '0;
            aw_have <= 1'b0;
            b_pend  <= 1'b0;
            ar_have <= 1'b0;
        end else begin
            lcg     <= lcg_next(lcg);
            // one random bit per channel when stalls are on
            awready <= !aw_have && !b_pend && !bvalid && (!stall_en || lcg[30]);
            wready  <= aw_have && (!stall_en || lcg[29]);
            arready <= !ar_have && (!stall_en || lcg[28]);

            if (awvalid && awready) begin
                aw_have <= 1'b1;
                w_idx   <= awaddr[11:2];
                w_err   <= (awaddr >= ERR_BASE);
            end
            if (wvalid && wready) begin
                if (!w_err)
                    mem[w_idx] <= wdata;
                w_idx <= w_idx + 1'b1;
                if (wlast) begin
                    aw_have <= 1'b0;
                    b_pend  <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pend && (!stall_en || lcg[27])) begin
                bvalid <= 1'b1;
                bresp  <= w_err ? SLVERR : OKAY;
                b_pend <= 1'b0;
            end

            if (arvalid && arready) begin
                ar_have <= 1'b1;
                r_idx   <= araddr[11:2];
                r_left  <= arlen;
                r_err   <= (araddr >= ERR_BASE);
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end
            if (ar_have && (!rvalid || rready)) begin   // next beat once the last one is gone
                rvalid  <= 1'b1;
                rdata   <= r_err ? '0 : mem[r_idx];
                rresp   <= r_err ? SLVERR : OKAY;
                rlast   <= (r_left == '0);
                r_idx   <= r_idx + 1'b1;
                r_left  <= r_left - 1'b1;
                ar_have <= (r_left != '0);
            end
        end
    end

endmodule

//--- tb_dma.sv
// tb_dma: testbench top with clock, reset, Wishbone tasks, directed tests and compare tasks
`timescale 1ns/1ps

module tb_dma;
    import dma_pkg::*;

    localparam int TIMEOUT       = 2000;     // bound for every wait loop
    localparam int BURST_SRC_IDX = 'h100;

    logic                clk;
    logic                rst;
    logic                wb_cyc, wb_stb, wb_we, wb_ack;
    logic [ADDR_W-1:0]   wb_adr;
    logic [DATA_W-1:0]   wb_wdata, wb_rdata;
    logic [ADDR_W-1:0]   awaddr, araddr;
    logic [LEN_W-1:0]    awlen, arlen;
    logic                awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic                arvalid, arready, rlast, rvalid, rready;
    logic [DATA_W-1:0]   wdata, rdata;
    logic [DATA_W/8-1:0] wstrb;
    logic [1:0]          bresp, rresp;
    logic                stall_en, bd_we;
    logic [9:0]          bd_idx;
    logic [DATA_W-1:0]   bd_wdata;
    logic [31:0]         rnd;
    int                  exp_len;
    logic [DATA_W-1:0]   burst_words [16];

    dma_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .BUF_DEPTH(BUF_DEPTH)) dut0 (.*);

    tb_axi_mem #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // background pattern built from every address bit
    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        return DATA_W'(32'h5a00_0000 ^ (idx * 32'h0001_0003));
    endfunction

    function automatic logic [DATA_W-1:0] mem_peek(input int idx);
        return mem0.mem[10'(idx)];
    endfunction

    task automatic mem_poke(input int idx, input logic [DATA_W-1:0] data);
        @(posedge clk);
        bd_we    <= 1'b1;
        bd_idx   <= 10'(idx);
        bd_wdata <= data;
        @(posedge clk);
        bd_we    <= 1'b0;
    endtask

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
            abort_run();
        end
    endtask

    // status word is {zeros, err[1:0], done, busy}
    task automatic check_status(input logic [DATA_W-1:0] status, input logic busy,
                                input logic done, input axi_resp_e err, input string what);
        if (status[1:0] !== {done, busy} || status[DATA_W-1:4] !== '0) begin
            $display("MISMATCH at %0t ns: %s busy=%b done=%b upper=%h, expected busy=%b done=%b",
                     $time, what, status[0], status[1], status[DATA_W-1:4], busy, done);
            abort_run();
        end
        check_resp(axi_resp_e'(status[3:2]), err, what);
    endtask

    // burst length and strobes seen at each AXI handshake
    always @(posedge clk) begin
        if (!rst && awvalid && awready)
            check_word(DATA_W'(awlen), DATA_W'(exp_len), "awlen");
        if (!rst && arvalid && arready)
            check_word(DATA_W'(arlen), DATA_W'(exp_len), "arlen");
        if (!rst && wvalid && wready)
            check_word(DATA_W'(wstrb), DATA_W'({(DATA_W/8){1'b1}}), "wstrb");
    end

    task automatic wb_access(input logic we, input reg_sel_e sel,
                             input logic [DATA_W-1:0] wr, output logic [DATA_W-1:0] rd);
        int   n;
        logic got_ack;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= ADDR_W'({sel, 2'b00});
        wb_wdata <= wr;
        got_ack = 1'b0;
        rd      = '0;
        for (n = 0; n < TIMEOUT && !got_ack; n++) begin
            @(posedge clk);
            got_ack = wb_ack;
            rd      = wb_rdata;
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!got_ack) begin
            $display("timeout waiting for wb_ack on register %s", sel.name());
            abort_run();
        end
        check_word(DATA_W'(n), 32'd2, "edges from stb to seen ack");
    endtask

    task automatic wb_write(input reg_sel_e sel, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused_rd;
        wb_access(1'b1, sel, data, unused_rd);
    endtask

    task automatic wb_read(input reg_sel_e sel, output logic [DATA_W-1:0] data);
        wb_access(1'b0, sel, '0, data);
    endtask

    task automatic wait_done(output logic [DATA_W-1:0] status);
        int n;
        status = '0;
        for (n = 0; n < TIMEOUT && !(status[1] && !status[0]); n++)
            wb_read(REG_CTRL, status);
        if (!(status[1] && !status[0])) begin
            $display("timeout waiting for the copy to report done");
            abort_run();
        end
    endtask

    task automatic run_copy(input int src_idx, input int dst_idx, input int len,
                            output logic [DATA_W-1:0] status);
        exp_len = len;
        wb_write(REG_SRC, DATA_W'(src_idx * 4));
        wb_write(REG_DST, DATA_W'(dst_idx * 4));
        wb_write(REG_LEN, DATA_W'(len));
        wb_write(REG_CTRL, 32'd1);
        wait_done(status);
    endtask

    task automatic burst_copy(input logic stalls, input int dst_idx);
        logic [DATA_W-1:0] st;
        int                i;
        stall_en <= stalls;
        run_copy(BURST_SRC_IDX, dst_idx, 15, st);
        stall_en <= 1'b0;
        check_status(st, 1'b0, 1'b1, OKAY, "burst copy status");
        for (i = 0; i < 16; i++)
            check_word(mem_peek(dst_idx + i), burst_words[i], $sformatf("burst word %0d", i));
        check_word(mem_peek(dst_idx + 16), fill_word(dst_idx + 16), "word after the burst");
    endtask

    task automatic register_readback();
        logic [DATA_W-1:0] rd;
        wb_read(REG_CTRL, rd);
        check_status(rd, 1'b0, 1'b0, OKAY, "status after reset");
        wb_write(REG_SRC, 32'hdead_beec);
        wb_write(REG_DST, 32'h1357_9bdc);
        wb_write(REG_LEN, 32'h0000_00a5);
        wb_read(REG_SRC, rd);
        check_word(rd, 32'hdead_beec, "source register");
        wb_read(REG_DST, rd);
        check_word(rd, 32'h1357_9bdc, "destination register");
        wb_read(REG_LEN, rd);
        check_word(rd, 32'h0000_00a5, "length register");
    endtask

    task automatic single_beat_copy();
        logic [DATA_W-1:0] st;
        run_copy('h040, 'h080, 0, st);
        check_status(st, 1'b0, 1'b1, OKAY, "single beat status");
        check_word(mem_peek('h080), fill_word('h040), "copied word");
        check_word(mem_peek('h07f), fill_word('h07f), "word below destination");
        check_word(mem_peek('h081), fill_word('h081), "word above destination");
    endtask

    task automatic full_burst_copy();
        int i;
        for (i = 0; i < 16; i++) begin
            rnd = lcg_next(rnd);
            burst_words[i] = rnd;
            mem_poke(BURST_SRC_IDX + i, rnd);
        end
        burst_copy(1'b0, 'h200);
    endtask

    task automatic stalled_burst_copy();
        burst_copy(1'b1, 'h300);     // same source words as the plain burst
    endtask

    task automatic ignored_second_start();
        logic [DATA_W-1:0] st;
        int                i;
        exp_len = 15;
        wb_write(REG_SRC, 32'h0000_0500);
        wb_write(REG_DST, 32'h0000_0a00);
        wb_write(REG_LEN, 32'd15);
        stall_en <= 1'b1;            // stretch the copy
        wb_write(REG_CTRL, 32'd1);
        wb_read(REG_CTRL, st);
        check_status(st, 1'b1, 1'b0, OKAY, "status during copy");
        wb_write(REG_DST, 32'h0000_0b00);
        wb_write(REG_CTRL, 32'd1);
        wait_done(st);
        stall_en <= 1'b0;
        check_status(st, 1'b0, 1'b1, OKAY, "status after second start");
        for (i = 0; i < 16; i++) begin
            check_word(mem_peek('h280 + i), fill_word('h140 + i), "first copy destination");
            check_word(mem_peek('h2c0 + i), fill_word('h2c0 + i), "second destination untouched");
        end
    endtask

    task automatic read_error_copy();
        logic [DATA_W-1:0] st;
        int                i;
        run_copy('hc00, 'h380, 3, st);    // source at 0x3000
        check_status(st, 1'b0, 1'b1, SLVERR, "read error status");
        for (i = 0; i < 4; i++)
            check_word(mem_peek('h380 + i), fill_word('h380 + i), "destination after read error");
    endtask

    initial begin
        int i;
        rst      <= 1'b1;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_wdata <= '0;
        stall_en <= 1'b0;
        bd_we    <= 1'b0;
        bd_idx   <= '0;
        bd_wdata <= '0;
        rnd = 32'd35;
        exp_len = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < 1024; i++)
            mem_poke(i, fill_word(i));
        register_readback();
        single_beat_copy();
        full_burst_copy();
        stalled_burst_copy();
        ignored_second_start();
        read_error_copy();
        $display("Test passed");
        $finish;
    end

endmodule

//--- files.f
dma_pkg.sv
axi4_burst_master.sv
burst_buffer.sv
wb_dma_regs.sv
dma_ctrl.sv
dma_top.sv
tb_axi_mem.sv
tb_dma.sv

//--- Makefile
SIM      = verilator
TOP      = tb_dma
FILELIST = files.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --timescale 1ns/1ps --top-module $(TOP) -Mdir $(OBJ_DIR)
LOG      = sim.log

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
